// File: all.f
cam_pkg.sv
cam_unpack.sv
line_fifo.sv
capture_ctrl.sv
byte_stream_out.sv
line_capture_top.sv
tb_line_capture.sv

// File: byte_stream_out.sv
`default_nettype none

module byte_stream_out (
    input  wire logic           rclk,
    input  wire logic           cam_vsync,
    input  wire logic           fetch,
    input  wire cam_pkg::row_t  fetch_row,
    input  wire logic           fetch_last,
    input  wire cam_pkg::byte_t rd_data,
    output logic                slot_free,
    output logic                out_valid,
    input  wire logic           out_ready,
    output cam_pkg::byte_t      out_data,
    output cam_pkg::row_t       out_row,
    output logic                out_last
);

    logic           d_valid;       // Byte arriving from the buffer this cycle
    cam_pkg::row_t  d_row;
    logic           d_last;

    cam_pkg::byte_t q_data [2];
    cam_pkg::row_t  q_row  [2];
    logic           q_last [2];
    logic           wr_idx;
    logic           rd_idx;
    logic [1:0]     count;
    logic [1:0]     occ;
    logic           push;
    logic           pop;
    logic           fin_fly;
    logic           fin_q;

    assign push = d_valid;
    assign pop  = out_valid && out_ready;

    assign out_valid = count != 2'd0;
    assign out_data  = q_data[rd_idx];
    assign out_row   = q_row[rd_idx];
    assign out_last  = q_last[rd_idx];

    // Frame-final byte still pending blocks slot_free, so the controller sees the drain
    assign fin_fly = d_valid && d_last && d_row == cam_pkg::row_t'(cam_pkg::V_ACT - 1);
    assign fin_q   = (count != 2'd0 && q_last[rd_idx]
                      && q_row[rd_idx] == cam_pkg::row_t'(cam_pkg::V_ACT - 1))
                     || (count == 2'd2 && q_last[!rd_idx]
                      && q_row[!rd_idx] == cam_pkg::row_t'(cam_pkg::V_ACT - 1));

    assign occ       = count + {1'b0, d_valid} - {1'b0, pop};
    assign slot_free = occ < 2'd2 && !fin_fly && !fin_q;

    always_ff @(posedge rclk) begin
        if (fetch) begin
            d_row  <= fetch_row;                   // Lines up with rd_data
            d_last <= fetch_last;
        end
        if (push) begin
            q_data[wr_idx] <= rd_data;
            q_row[wr_idx]  <= d_row;
            q_last[wr_idx] <= d_last;
        end
    end

    always_ff @(posedge rclk or posedge cam_vsync) begin
        if (cam_vsync) begin
            d_valid <= 1'b0;
            wr_idx  <= 1'b0;
            rd_idx  <= 1'b0;
            count   <= 2'd0;
        end else begin
            d_valid <= fetch;
            if (push) begin
                wr_idx <= !wr_idx;
            end
            if (pop) begin
                rd_idx <= !rd_idx;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    a_stall_stable : assert property (
        @(posedge rclk) disable iff (cam_vsync)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
            && $stable(out_row) && $stable(out_last)
    );

endmodule : byte_stream_out

`default_nettype wire

// File: cam_pkg.sv
`default_nettype none

package cam_pkg;

    // Frame geometry of this build
    localparam int H_ACT = 16;
    localparam int V_ACT = 4;

    localparam int LINE_BYTES = 2 * H_ACT;     // Two bytes per RGB565 pixel
    localparam int FIFO_PIX   = 2 * H_ACT;     // Room for two rows

    localparam int COL_W  = $clog2(H_ACT);
    localparam int ROW_W  = $clog2(V_ACT);
    localparam int LVL_W  = $clog2(2 * FIFO_PIX + 1);
    localparam int PTR_W  = $clog2(FIFO_PIX);
    localparam int BCNT_W = $clog2(LINE_BYTES);

    typedef logic [7:0]        chan_t;
    typedef logic [15:0]       pix565_t;
    typedef logic [7:0]        byte_t;
    typedef logic [COL_W-1:0]  col_t;
    typedef logic [ROW_W-1:0]  row_t;
    typedef logic [LVL_W-1:0]  lvl_t;      // Bytes held in the line buffer
    typedef logic [PTR_W-1:0]  ptr_t;      // Pixel slot in the line buffer
    typedef logic [BCNT_W-1:0] bcnt_t;     // Byte position inside a row

    typedef enum logic [2:0] {
        IDLE,
        ARMED,
        WAIT_LINE,
        READ_LINE,
        DONE
    } cap_state_t;

endpackage : cam_pkg

`default_nettype wire

// File: cam_unpack.sv
`default_nettype none

module cam_unpack (
    input  wire logic             rclk,
    input  wire logic             cam_vsync,
    input  wire logic             cam_de,
    input  wire cam_pkg::chan_t   cam_r,
    input  wire cam_pkg::chan_t   cam_g,
    input  wire cam_pkg::chan_t   cam_b,
    output logic                  pix_valid,
    output cam_pkg::pix565_t      pix_data,
    output cam_pkg::col_t         pix_col,
    output cam_pkg::row_t         pix_row
);

    cam_pkg::col_t col_cnt;    // Position of the next incoming pixel
    cam_pkg::row_t row_cnt;

    always_ff @(posedge rclk or posedge cam_vsync) begin
        if (cam_vsync) begin
            pix_valid <= 1'b0;
            pix_col   <= '0;
            pix_row   <= '0;
            col_cnt   <= '0;
            row_cnt   <= '0;
        end else begin
            pix_valid <= cam_de;
            if (cam_de) begin
                pix_col <= col_cnt;
                pix_row <= row_cnt;
                if (col_cnt == cam_pkg::col_t'(cam_pkg::H_ACT - 1)) begin
                    col_cnt <= '0;
                    if (row_cnt == cam_pkg::row_t'(cam_pkg::V_ACT - 1)) begin
                        row_cnt <= '0;             // Next frame
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // Keep the top bits of each channel
    always_ff @(posedge rclk) begin
        if (cam_de) begin
            pix_data <= {cam_r[7:3], cam_g[7:2], cam_b[7:3]};
        end
    end

endmodule : cam_unpack

`default_nettype wire

// File: capture_ctrl.sv
`default_nettype none

module capture_ctrl (
    input  wire logic          rclk,
    input  wire logic          cam_vsync,
    input  wire logic          trig,
    input  wire logic          pix_valid,
    input  wire cam_pkg::col_t pix_col,
    input  wire cam_pkg::row_t pix_row,
    input  wire cam_pkg::lvl_t level,
    input  wire logic          slot_free,
    output logic               wr_en,
    output logic               rd_en,
    output cam_pkg::row_t      fetch_row,
    output logic               fetch_last,
    output logic               busy
);

    cam_pkg::cap_state_t state;
    cam_pkg::row_t       row_cnt;      // Row being read out
    cam_pkg::bcnt_t      byte_cnt;     // Byte inside that row
    logic                writing;      // Frame pixels still arriving
    logic                start_pix;
    logic                end_pix;
    logic                line_ready;

    assign start_pix  = pix_valid && pix_col == '0 && pix_row == '0;
    assign end_pix    = pix_valid
                        && pix_col == cam_pkg::col_t'(cam_pkg::H_ACT - 1)
                        && pix_row == cam_pkg::row_t'(cam_pkg::V_ACT - 1);
    assign line_ready = level >= cam_pkg::lvl_t'(cam_pkg::LINE_BYTES);

    // The start pixel itself is stored
    assign wr_en = pix_valid && (writing || (state == cam_pkg::ARMED && start_pix));

    assign rd_en      = state == cam_pkg::READ_LINE && slot_free;
    assign fetch_row  = row_cnt;
    assign fetch_last = byte_cnt == cam_pkg::bcnt_t'(cam_pkg::LINE_BYTES - 1);
    assign busy       = state != cam_pkg::IDLE;

    always_ff @(posedge rclk or posedge cam_vsync) begin
        if (cam_vsync) begin
            writing <= 1'b0;
        end else if (state == cam_pkg::ARMED && start_pix) begin
            writing <= 1'b1;
        end else if (writing && end_pix) begin
            writing <= 1'b0;                       // Last pixel of the frame written
        end
    end

    always_ff @(posedge rclk or posedge cam_vsync) begin
        if (cam_vsync) begin
            state    <= cam_pkg::IDLE;
            row_cnt  <= '0;
            byte_cnt <= '0;
        end else begin
            case (state)
                cam_pkg::IDLE: begin
                    if (trig) begin
                        state <= cam_pkg::ARMED;
                    end
                end
                cam_pkg::ARMED: begin
                    if (start_pix) begin
                        state <= cam_pkg::WAIT_LINE;
                    end
                end
                cam_pkg::WAIT_LINE: begin
                    if (line_ready) begin
                        state <= cam_pkg::READ_LINE;
                    end
                end
                cam_pkg::READ_LINE: begin
                    if (rd_en) begin
                        if (fetch_last) begin
                            byte_cnt <= '0;
                            if (row_cnt == cam_pkg::row_t'(cam_pkg::V_ACT - 1)) begin
                                row_cnt <= '0;
                                state   <= cam_pkg::DONE;
                            end else begin
                                row_cnt <= row_cnt + 1'b1;
                                state   <= cam_pkg::WAIT_LINE;
                            end
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                cam_pkg::DONE: begin
                    // Output queue drained, final byte taken
                    if (slot_free) begin
                        state <= cam_pkg::IDLE;
                    end
                end
                default: begin
                    state <= cam_pkg::IDLE;
                end
            endcase
        end
    end

    a_state_legal : assert property (
        @(posedge rclk) disable iff (cam_vsync)
        !$isunknown(state) && state inside {cam_pkg::IDLE, cam_pkg::ARMED,
            cam_pkg::WAIT_LINE, cam_pkg::READ_LINE, cam_pkg::DONE}
    );

endmodule : capture_ctrl

`default_nettype wire

// File: line_capture_top.sv
`default_nettype none

module line_capture_top (
    input  wire logic           rclk,
    input  wire logic           cam_vsync,
    input  wire logic           trig,
    input  wire logic           cam_de,
    input  wire cam_pkg::chan_t cam_r,
    input  wire cam_pkg::chan_t cam_g,
    input  wire cam_pkg::chan_t cam_b,
    input  wire logic           out_ready,
    output logic                out_valid,
    output cam_pkg::byte_t      out_data,
    output cam_pkg::row_t       out_row,
    output logic                out_last,
    output logic                busy,
    output logic                error
);

    logic             pix_valid;
    cam_pkg::pix565_t pix_data;
    cam_pkg::col_t    pix_col;
    cam_pkg::row_t    pix_row;
    logic             wr_en;
    logic             rd_en;           // Also the fetch strobe
    cam_pkg::byte_t   rd_data;
    cam_pkg::lvl_t    level;
    logic             slot_free;
    cam_pkg::row_t    fetch_row;
    logic             fetch_last;

    cam_unpack u_unpack (
        .rclk      (rclk),
        .cam_vsync (cam_vsync),
        .cam_de    (cam_de),
        .cam_r     (cam_r),
        .cam_g     (cam_g),
        .cam_b     (cam_b),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_col   (pix_col),
        .pix_row   (pix_row)
    );

    line_fifo u_fifo (
        .rclk      (rclk),
        .cam_vsync (cam_vsync),
        .wr_en     (wr_en),
        .wr_data   (pix_data),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .level     (level),
        .overflow  (error)
    );

    capture_ctrl u_ctrl (
        .rclk       (rclk),
        .cam_vsync  (cam_vsync),
        .trig       (trig),
        .pix_valid  (pix_valid),
        .pix_col    (pix_col),
        .pix_row    (pix_row),
        .level      (level),
        .slot_free  (slot_free),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .fetch_row  (fetch_row),
        .fetch_last (fetch_last),
        .busy       (busy)
    );

    byte_stream_out u_out (
        .rclk       (rclk),
        .cam_vsync  (cam_vsync),
        .fetch      (rd_en),
        .fetch_row  (fetch_row),
        .fetch_last (fetch_last),
        .rd_data    (rd_data),
        .slot_free  (slot_free),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_row    (out_row),
        .out_last   (out_last)
    );

endmodule : line_capture_top

`default_nettype wire

// File: line_fifo.sv
`default_nettype none

module line_fifo (
    input  wire logic             rclk,
    input  wire logic             cam_vsync,
    input  wire logic             wr_en,
    input  wire cam_pkg::pix565_t wr_data,
    input  wire logic             rd_en,
    output cam_pkg::byte_t        rd_data,
    output cam_pkg::lvl_t         level,
    output logic                  overflow
);

    cam_pkg::pix565_t mem [cam_pkg::FIFO_PIX];

    cam_pkg::ptr_t wr_ptr;
    cam_pkg::ptr_t rd_ptr;
    logic          rd_lo;      // Next read takes the low byte
    logic          full;
    logic          wr_ok;

    // A partly read pixel still occupies its slot
    assign full  = level > cam_pkg::lvl_t'(2 * cam_pkg::FIFO_PIX - 2);
    assign wr_ok = wr_en && !full;

    always_ff @(posedge rclk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge rclk) begin
        if (rd_en) begin
            rd_data <= rd_lo ? mem[rd_ptr][7:0] : mem[rd_ptr][15:8];
        end
    end

    always_ff @(posedge rclk or posedge cam_vsync) begin
        if (cam_vsync) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_lo    <= 1'b0;
            level    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_ok) begin
                if (wr_ptr == cam_pkg::ptr_t'(cam_pkg::FIFO_PIX - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end

            if (rd_en) begin
                rd_lo <= !rd_lo;
                if (rd_lo) begin                   // Pixel fully consumed
                    if (rd_ptr == cam_pkg::ptr_t'(cam_pkg::FIFO_PIX - 1)) begin
                        rd_ptr <= '0;
                    end else begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                end
            end

            level <= level + cam_pkg::lvl_t'({wr_ok, 1'b0}) - cam_pkg::lvl_t'(rd_en);

            if (wr_en && full) begin
                overflow <= 1'b1;                  // Sticky until vsync
            end
        end
    end

    // The controller must only fetch bytes that are stored
    a_no_read_empty : assert property (
        @(posedge rclk) disable iff (cam_vsync)
        rd_en |-> level != '0
    );

    a_level_bound : assert property (
        @(posedge rclk) disable iff (cam_vsync)
        level <= cam_pkg::lvl_t'(2 * cam_pkg::FIFO_PIX)
    );

endmodule : line_fifo

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_line_capture -f all.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || echo "Build or run stopped early"
grep -qx "Simulation PASSED" sim.log 2>/dev/null \
    && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }

// File: tb_line_capture.sv
`default_nettype none

module tb_line_capture;

    timeunit 1ns;
    timeprecision 1ps;

    logic           rclk;
    logic           cam_vsync;
    logic           trig;
    logic           cam_de;
    cam_pkg::chan_t cam_r;
    cam_pkg::chan_t cam_g;
    cam_pkg::chan_t cam_b;
    logic           out_ready;
    logic           out_valid;
    cam_pkg::byte_t out_data;
    cam_pkg::row_t  out_row;
    logic           out_last;
    logic           busy;
    logic           error;

    cam_pkg::chan_t pic_r [cam_pkg::H_ACT * cam_pkg::V_ACT];     // Current test picture
    cam_pkg::chan_t pic_g [cam_pkg::H_ACT * cam_pkg::V_ACT];
    cam_pkg::chan_t pic_b [cam_pkg::H_ACT * cam_pkg::V_ACT];

    cam_pkg::byte_t exp_data [$];      // Bytes the DUT still owes
    cam_pkg::row_t  exp_row  [$];
    logic           exp_last [$];

    int  ready_mode = 1;               // 0 low, 1 high, 2 random
    int  err_cnt    = 0;
    int  mon_errs   = 0;
    int  errs_seen  = 0;
    int  tests_ok   = 0;
    int  tests_bad  = 0;
    time last_xfer  = 0;

    line_capture_top UUT (
        .rclk      (rclk),
        .cam_vsync (cam_vsync),
        .trig      (trig),
        .cam_de    (cam_de),
        .cam_r     (cam_r),
        .cam_g     (cam_g),
        .cam_b     (cam_b),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_row   (out_row),
        .out_last  (out_last),
        .busy      (busy),
        .error     (error)
    );

    initial begin
        rclk = 1'b0;
        forever #4 rclk = ~rclk;
    end

    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge rclk);
            case (ready_mode)
                0: out_ready = 1'b0;
                1: out_ready = 1'b1;
                default: out_ready = ($urandom % 4) != 0;     // High three cycles in four
            endcase
        end
    end

    // RGB565 keeps the top 5, 6 and 5 bits of red, green and blue
    function automatic cam_pkg::pix565_t rgb565(input cam_pkg::chan_t r,
                                                input cam_pkg::chan_t g,
                                                input cam_pkg::chan_t b);
        int v;
        v = (int'(r) / 8) * 2048 + (int'(g) / 4) * 32 + int'(b) / 8;
        return cam_pkg::pix565_t'(v);
    endfunction

    task automatic check_byte(input string name, input cam_pkg::byte_t got,
                              input cam_pkg::byte_t want, inout int errs);
        if (got !== want) begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, want);
            errs++;
        end
    endtask

    task automatic check_row(input string name, input cam_pkg::row_t got,
                             input cam_pkg::row_t want, inout int errs);
        if (got !== want) begin
            $display("FAILED at %0d ns: %s is %0d, expected %0d", $time, name, got, want);
            errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got,
                              input logic want, inout int errs);
        if (got !== want) begin
            $display("FAILED at %0d ns: %s is %b, expected %b", $time, name, got, want);
            errs++;
        end
    endtask

    always @(posedge rclk) begin
        if (!cam_vsync && out_valid && out_ready) begin
            last_xfer = $time;
            if (exp_data.size() == 0) begin
                $display("Unexpected byte %h left the DUT at %0d ns", out_data, $time);
                mon_errs++;
            end else begin
                check_byte("out_data", out_data, exp_data.pop_front(), mon_errs);
                check_row("out_row", out_row, exp_row.pop_front(), mon_errs);
                check_flag("out_last", out_last, exp_last.pop_front(), mon_errs);
                check_flag("busy", busy, 1'b1, mon_errs);
            end
        end
    end

    task automatic fill_picture();
        int k;
        for (k = 0; k < cam_pkg::H_ACT * cam_pkg::V_ACT; k++) begin
            pic_r[k] = cam_pkg::chan_t'($urandom);
            pic_g[k] = cam_pkg::chan_t'($urandom);
            pic_b[k] = cam_pkg::chan_t'($urandom);
        end
    endtask

    // Sends one frame; trig pulses in the blanking before row trig_row
    task automatic drive_frame(input bit capture, input int trig_row);
        int row;
        int col;
        int i;
        int gap;
        int idx;
        cam_pkg::pix565_t px;
        for (row = 0; row < cam_pkg::V_ACT; row++) begin
            gap = 40 + int'($urandom % 21);
            for (i = 0; i < gap; i++) begin
                @(negedge rclk);
                if (row == trig_row && i == gap / 2) begin
                    check_flag("busy", busy, 1'b0, err_cnt);
                end
                if (row == trig_row && i == gap / 2 + 1) begin
                    check_flag("busy", busy, 1'b1, err_cnt);     // One cycle after trig
                end
                cam_de = 1'b0;
                trig   = (row == trig_row) && (i == gap / 2);
            end
            for (col = 0; col < cam_pkg::H_ACT; col++) begin
                idx = row * cam_pkg::H_ACT + col;
                @(negedge rclk);
                cam_de = 1'b1;
                cam_r  = pic_r[idx];
                cam_g  = pic_g[idx];
                cam_b  = pic_b[idx];
                if (capture) begin
                    px = rgb565(pic_r[idx], pic_g[idx], pic_b[idx]);
                    exp_data.push_back(px[15:8]);            // High byte leaves first
                    exp_row.push_back(cam_pkg::row_t'(row));
                    exp_last.push_back(1'b0);
                    exp_data.push_back(px[7:0]);
                    exp_row.push_back(cam_pkg::row_t'(row));
                    exp_last.push_back(col == cam_pkg::H_ACT - 1);
                end
            end
        end
        @(negedge rclk);
        cam_de = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_data.size() != 0 && n < limit) begin
            @(negedge rclk);
            n++;
        end
        if (exp_data.size() != 0) begin
            $display("Timeout: %0d expected bytes never came out", exp_data.size());
            err_cnt++;
            exp_data.delete();
            exp_row.delete();
            exp_last.delete();
        end
    endtask

    task automatic wait_busy_low(input int limit);
        int n;
        n = 0;
        while (busy && n < limit) begin
            @(negedge rclk);
            n++;
        end
        if (busy) begin
            $display("Timeout: busy still high after %0d cycles", limit);
            err_cnt++;
        end else if ($time - last_xfer != 12) begin    // Falling-edge view of one cycle
            $display("busy fell %0d ns after the last transfer, not one cycle", $time - last_xfer);
            err_cnt++;
        end
    endtask

    task automatic watch_outputs(input int cycles, input logic valid_want,
                                 input logic busy_want, input logic error_want);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge rclk);
            check_flag("out_valid", out_valid, valid_want, err_cnt);
            check_flag("busy", busy, busy_want, err_cnt);
            check_flag("error", error, error_want, err_cnt);
        end
    endtask

    task automatic apply_reset();
        cam_vsync = 1'b1;
        watch_outputs(2, 1'b0, 1'b0, 1'b0);
        cam_vsync = 1'b0;
        watch_outputs(1, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic end_test(input string name);
        int now_errs;
        now_errs = err_cnt + mon_errs;
        if (now_errs == errs_seen) begin
            tests_ok++;
            $display("test %s: pass", name);
        end else begin
            tests_bad++;
            $display("test %s: fail with %0d errors", name, now_errs - errs_seen);
        end
        errs_seen = now_errs;
    endtask

    initial begin
        void'($urandom(98906));
        cam_vsync = 1'b1;
        trig      = 1'b0;
        cam_de    = 1'b0;
        cam_r     = '0;
        cam_g     = '0;
        cam_b     = '0;
        apply_reset();
        fill_picture();

        ready_mode = 1;
        drive_frame(1'b1, 0);
        wait_drain(500);
        wait_busy_low(100);
        check_flag("error", error, 1'b0, err_cnt);
        end_test("1 full frame with out_ready high");

        ready_mode = 2;
        drive_frame(1'b1, 0);                    // Same picture, same byte stream
        wait_drain(1000);
        wait_busy_low(100);
        check_flag("error", error, 1'b0, err_cnt);
        end_test("2 same frame with random out_ready");

        ready_mode = 1;
        fill_picture();
        drive_frame(1'b0, 1);
        check_flag("out_valid", out_valid, 1'b0, err_cnt);
        check_flag("busy", busy, 1'b1, err_cnt);
        drive_frame(1'b1, -1);
        wait_drain(500);
        end_test("3 trig in the middle of a frame");

        wait_busy_low(100);
        drive_frame(1'b0, -1);
        watch_outputs(40, 1'b0, 1'b0, 1'b0);
        end_test("4 busy window and silence after capture");

        ready_mode = 0;
        drive_frame(1'b0, 0);
        watch_outputs(20, 1'b1, 1'b1, 1'b1);     // Stream stalled, error held
        apply_reset();
        end_test("5 overflow and clear by cam_vsync");

        $display("%0d tests passed, %0d tests failed", tests_ok, tests_bad);
        if (tests_bad == 0 && err_cnt + mon_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : tb_line_capture

`default_nettype wire
